//--- common/panel_defs.svh
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Front panel defaults
////////////////////////////////////////////////////////////////////////////

// Stable cycles before a debounced input may change
// 10 ms at 100 MHz
`define PANEL_DEBOUNCE_COUNT 1000000

// Scan divider width
// Each digit stays lit for 2**17 cycles
`define PANEL_REFRESH_BITS 17

// Press counter width
// Two hex digits per count so this stays at 8
`define PANEL_COUNT_W 8

`endif

//--- common/panel_pkg.sv
package panel_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Push buttons
   ////////////////////////////////////////////////////////////////////////////

   // One level per board button
   // Field order fixes the bit order in the 5-bit vector
   typedef struct packed {
      // BTNL
      logic left;
      // BTNR
      logic right;
      // BTNU
      logic up;
      // BTND
      logic down;
      // BTNC clears the counters
      logic center;
   } btn_t;

   ////////////////////////////////////////////////////////////////////////////
   // Seven-segment display
   ////////////////////////////////////////////////////////////////////////////

   // Eight hex nibbles
   // Index 7 is the leftmost digit and index 0 the rightmost
   typedef logic [7:0][3:0] disp_word_t;

   // Four-phase load from the controller to the display driver
   // Ack travels back on its own wire
   typedef struct packed {
      // Raised with a new word and dropped after ack
      logic       req;
      // Held steady for as long as req is high
      disp_word_t word;
   } disp_load_t;

endpackage

//--- debounce/debounce.sv
`timescale 1ns/1ps
`include "panel_defs.svh"

module debounce #(
   parameter type         payload_t = logic,
   parameter int unsigned COUNT     = `PANEL_DEBOUNCE_COUNT
) (
   input  logic     clk,
   input  logic     rst_n,
   input  payload_t noisy,
   output payload_t clean
);

   // Counter just wide enough for COUNT-1
   localparam int unsigned CNT_W = (COUNT > 1) ? $clog2(COUNT) : 1;

   // Raw input one cycle late
   payload_t   sample;
   // Cycles the input has matched the sample
   logic [CNT_W-1:0] stable_cnt;
   logic       same;
   logic       settled;

   // Input unchanged since the last edge
   assign same    = (noisy == sample);
   // Last matching cycle of the run
   assign settled = same && (stable_cnt == CNT_W'(COUNT - 1));

   ////////////////////////////////////////////////////////////////////////////
   // Sample, stability count and output
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sample     <= '0;
         stable_cnt <= '0;
         clean      <= '0;
      end else begin
         sample <= noisy;
         if (!same) begin
            // Any change restarts the run
            stable_cnt <= '0;
         end else if (settled) begin
            // Held at the top while the input stays put
            clean <= sample;
         end else begin
            stable_cnt <= stable_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // A new output value always comes from the sample register
   // Never straight from the raw pin
   clean_from_sample: assert property (
      @(posedge clk) disable iff (!rst_n)
      $changed(clean) |-> (clean == $past(sample))
   ) else $error("debounce output took a value that was not sampled");

endmodule

//--- display/display_8hex.sv
`timescale 1ns/1ps
`include "panel_defs.svh"

module display_8hex #(
   parameter int unsigned REFRESH_BITS = `PANEL_REFRESH_BITS
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  panel_pkg::disp_load_t load,
   output logic                  ack,
   output logic [7:0]            seg,
   output logic [7:0]            an
);

   // Word on show
   panel_pkg::disp_word_t word_q;
   // Free-running scan divider
   logic [REFRESH_BITS-1:0] div;
   // Digit being lit
   logic [2:0]  digit;
   logic [2:0]  digit_next;
   logic        slot_end;

   // Hex nibble to active-low segments
   // Bit 0 is segment A up to bit 6 for segment G
   function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
      logic [6:0] s;
      case (nib)
         4'h0: s = 7'b100_0000;
         4'h1: s = 7'b111_1001;
         4'h2: s = 7'b010_0100;
         4'h3: s = 7'b011_0000;
         4'h4: s = 7'b001_1001;
         4'h5: s = 7'b001_0010;
         4'h6: s = 7'b000_0010;
         4'h7: s = 7'b111_1000;
         4'h8: s = 7'b000_0000;
         4'h9: s = 7'b001_0000;
         4'hA: s = 7'b000_1000;
         // Lower case b
         4'hB: s = 7'b000_0011;
         4'hC: s = 7'b100_0110;
         // Lower case d
         4'hD: s = 7'b010_0001;
         4'hE: s = 7'b000_0110;
         default: s = 7'b000_1110;
      endcase
      return s;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Load port responder
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ack    <= 1'b0;
         word_q <= '0;
      end else begin
         if (load.req && !ack) begin
            // Take the word and answer in the same edge
            word_q <= load.word;
            ack    <= 1'b1;
         end else if (!load.req && ack) begin
            // Req gone so close the cycle
            ack <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Digit scan
   ////////////////////////////////////////////////////////////////////////////

   // Last cycle of the current slot
   assign slot_end   = &div;
   // Wraps from 7 back to 0
   assign digit_next = digit + 3'd1;

   // Outputs change only on slot boundaries
   // A fresh word shows up from the next slot on
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         div   <= '0;
         digit <= '0;
         an    <= 8'b1111_1110;
         seg   <= {1'b1, hex_to_seg(4'h0)};
      end else begin
         div <= div + 1'b1;
         if (slot_end) begin
            digit <= digit_next;
            an    <= ~(8'b0000_0001 << digit_next);
            // Decimal point held dark
            seg   <= {1'b1, hex_to_seg(word_q[digit_next])};
         end
      end
   end

   // One digit enabled at any time
   an_one_low: assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot(~an)
   ) else $error("display anode strobe not one-cold");

endmodule

//--- design/panel_ctrl.sv
`timescale 1ns/1ps
`include "panel_defs.svh"

module panel_ctrl (
   input  logic                  clk,
   input  logic                  rst_n,
   input  panel_pkg::btn_t       buttons,
   output panel_pkg::disp_load_t load,
   input  logic                  ack
);

   localparam int unsigned CNT_W = `PANEL_COUNT_W;

   // Buttons one cycle late for edge detection
   panel_pkg::btn_t btn_q;
   // Rising edges this cycle
   panel_pkg::btn_t rise;
   // Increment strobes
   // Index 3 is left then right then up and index 0 is down
   logic [3:0] inc;
   // Press counters in the same order
   logic [3:0][CNT_W-1:0] cnt;
   // Counters packed as the display word
   panel_pkg::disp_word_t cnt_word;
   // A counter is written this cycle
   logic changed;
   // Counts moved since the last word went out
   logic pending;
   // Start a new transfer
   logic launch;

   ////////////////////////////////////////////////////////////////////////////
   // Edge detection and press counters
   ////////////////////////////////////////////////////////////////////////////

   assign rise    = panel_pkg::btn_t'(buttons & ~btn_q);
   assign inc     = {rise.left, rise.right, rise.up, rise.down};
   assign changed = rise.center | (|inc);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         btn_q <= '0;
         cnt   <= '0;
      end else begin
         btn_q <= buttons;
         if (rise.center) begin
            // Center wins over any other edge
            cnt <= '0;
         end else begin
            for (int i = 0; i < 4; i++) begin
               // Wraps at 256
               if (inc[i]) begin
                  cnt[i] <= cnt[i] + 1'b1;
               end
            end
         end
      end
   end

   // Left in digits 7 and 6 down to down in digits 1 and 0
   assign cnt_word = panel_pkg::disp_word_t'(cnt);

   ////////////////////////////////////////////////////////////////////////////
   // Four-phase initiator
   ////////////////////////////////////////////////////////////////////////////

   // Bus idle only when both req and ack are low
   assign launch = pending && !load.req && !ack;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         load    <= '0;
         pending <= 1'b0;
      end else begin
         // Stays set if the counts move in the launch cycle
         pending <= (pending && !launch) || changed;
         if (launch) begin
            // Always the latest counts
            // Older words in between are dropped
            load.req  <= 1'b1;
            load.word <= cnt_word;
         end else if (load.req && ack) begin
            load.req <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Handshake checks
   ////////////////////////////////////////////////////////////////////////////

   // Word frozen for the whole req phase
   word_held: assert property (
      @(posedge clk) disable iff (!rst_n)
      (load.req && $past(load.req)) |-> (load.word == $past(load.word))
   ) else $error("display word changed while req was high");

   // No new req before the display has dropped ack
   req_after_ack: assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(load.req) |-> !$past(ack)
   ) else $error("req raised while ack still high");

endmodule

//--- design/nexys4_panel.sv
`timescale 1ns/1ps
`include "panel_defs.svh"

module nexys4_panel #(
   parameter int unsigned DEBOUNCE_COUNT = `PANEL_DEBOUNCE_COUNT,
   parameter int unsigned REFRESH_BITS   = `PANEL_REFRESH_BITS
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] sw,
   input  logic        btnc,
   input  logic        btnu,
   input  logic        btnl,
   input  logic        btnr,
   input  logic        btnd,
   output logic [15:0] led,
   output logic        led16_r,
   output logic        led16_g,
   output logic        led16_b,
   output logic        led17_r,
   output logic        led17_g,
   output logic        led17_b,
   output logic [7:0]  seg,
   output logic [7:0]  an
);

   // Raw and clean button bundles
   panel_pkg::btn_t btn_raw;
   panel_pkg::btn_t btn_clean;
   // Clean switches
   logic [15:0] sw_clean;
   // Controller to display
   panel_pkg::disp_load_t disp_load;
   logic disp_ack;

   ////////////////////////////////////////////////////////////////////////////
   // Debounce
   ////////////////////////////////////////////////////////////////////////////

   assign btn_raw = '{left: btnl, right: btnr, up: btnu, down: btnd, center: btnc};

   // Five buttons as one payload
   debounce #(
      .payload_t (panel_pkg::btn_t),
      .COUNT     (DEBOUNCE_COUNT)
   ) btn_debounce (
      .clk   (clk),
      .rst_n (rst_n),
      .noisy (btn_raw),
      .clean (btn_clean)
   );

   // Sixteen slide switches
   debounce #(
      .payload_t (logic [15:0]),
      .COUNT     (DEBOUNCE_COUNT)
   ) sw_debounce (
      .clk   (clk),
      .rst_n (rst_n),
      .noisy (sw),
      .clean (sw_clean)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Counters and display
   ////////////////////////////////////////////////////////////////////////////

   panel_ctrl panel_ctrl_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .buttons (btn_clean),
      .load    (disp_load),
      .ack     (disp_ack)
   );

   display_8hex #(
      .REFRESH_BITS (REFRESH_BITS)
   ) display_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .load  (disp_load),
      .ack   (disp_ack),
      .seg   (seg),
      .an    (an)
   );

   // Switch LEDs follow the clean switches
   assign led = sw_clean;

   // Left and up on LED17
   assign led17_r = btn_clean.left;
   assign led17_g = btn_clean.up;
   assign led17_b = btn_clean.left & btn_clean.up;
   // Right and down on LED16
   assign led16_r = btn_clean.right;
   assign led16_g = btn_clean.down;
   assign led16_b = btn_clean.right & btn_clean.down;

endmodule

//--- testbench/tb_nexys4_panel.sv
`timescale 1ns/1ps

module tb_nexys4_panel;

   localparam int DEBOUNCE_COUNT = 8;
   localparam int REFRESH_BITS   = 2;
   localparam int CLK_PERIOD     = 10;
   // One pass over all eight digits
   localparam int SCAN_CYCLES    = 8 * (1 << REFRESH_BITS);
   localparam int HOLD_CYCLES    = 20;
   localparam int BOUNCE_TOGGLES = 6;
   localparam int PRESS_CYCLES   = 2 * HOLD_CYCLES + 2 * BOUNCE_TOGGLES;
   localparam int LED_CYCLES     = DEBOUNCE_COUNT + 4;
   localparam int SETTLE_CYCLES  = LED_CYCLES + SCAN_CYCLES;
   localparam int READ_CYCLES    = 2 * SCAN_CYCLES;
   localparam int CHECK_CYCLES   = SETTLE_CYCLES + READ_CYCLES;
   // Worst case per test summed, then some slack
   localparam int WATCHDOG_CYCLES = 2 + CHECK_CYCLES + 3 * (LED_CYCLES + 3)
      + 11 * PRESS_CYCLES + CHECK_CYCLES + 2 * (PRESS_CYCLES + CHECK_CYCLES)
      + 4 * LED_CYCLES + CHECK_CYCLES + 200;

   logic        clk;
   logic        rst_n;
   logic [15:0] sw;
   logic        btnc, btnu, btnl, btnr, btnd;
   logic [15:0] led;
   logic        led16_r, led16_g, led16_b;
   logic        led17_r, led17_g, led17_b;
   logic [7:0]  seg;
   logic [7:0]  an;

   int value_errors;
   int other_errors;
   // Model of the four press counters, left right up down
   logic [7:0] exp_cnt [4];
   // Lit segments per hex digit, active high, bit 0 is A
   logic [6:0] lit_table [16];
   int unsigned seed_ret;

   nexys4_panel #(
      .DEBOUNCE_COUNT (DEBOUNCE_COUNT),
      .REFRESH_BITS   (REFRESH_BITS)
   ) nexys4_panel_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .sw      (sw),
      .btnc    (btnc),
      .btnu    (btnu),
      .btnl    (btnl),
      .btnr    (btnr),
      .btnd    (btnd),
      .led     (led),
      .led16_r (led16_r),
      .led16_g (led16_g),
      .led16_b (led16_b),
      .led17_r (led17_r),
      .led17_g (led17_g),
      .led17_b (led17_b),
      .seg     (seg),
      .an      (an)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Hung run guard
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the tests did not finish in time");
      $display("FAIL: see errors above");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // 0 left, 1 right, 2 up, 3 down, 4 center
   task automatic set_button(input int which, input logic val);
      case (which)
         0: btnl = val;
         1: btnr = val;
         2: btnu = val;
         3: btnd = val;
         default: btnc = val;
      endcase
   endtask

   // Optional bounce burst, then a clean hold and release
   task automatic press(input int which, input int toggles);
      for (int k = 0; k < toggles; k++) begin
         set_button(which, (k % 2 == 0));
         repeat (2) @(negedge clk);
      end
      set_button(which, 1'b1);
      repeat (HOLD_CYCLES) @(negedge clk);
      set_button(which, 1'b0);
      repeat (HOLD_CYCLES) @(negedge clk);
   endtask

   // Model update for one counted press
   task automatic count_press(input int which);
      if (which == 4) begin
         for (int i = 0; i < 4; i++) exp_cnt[i] = 8'h00;
      end else begin
         exp_cnt[which] = exp_cnt[which] + 8'h01;
      end
   endtask

   function automatic logic [31:0] expected_word();
      return {exp_cnt[0], exp_cnt[1], exp_cnt[2], exp_cnt[3]};
   endfunction

   // Gather one nibble per anode from the scan
   task automatic read_display(output logic [31:0] word, output bit ok);
      logic [7:0] seen;
      int         digit;
      bit         hit;
      seen = '0;
      word = '0;
      ok   = 1'b1;
      for (int c = 0; c < READ_CYCLES && seen != 8'hFF; c++) begin
         @(negedge clk);
         digit = -1;
         for (int i = 0; i < 8; i++) begin
            if (an == ~(8'h01 << i)) digit = i;
         end
         if (digit >= 0 && !seen[digit]) begin
            seen[digit] = 1'b1;
            hit = 1'b0;
            for (int n = 0; n < 16; n++) begin
               if (seg[6:0] == ~lit_table[n]) begin
                  word[digit*4 +: 4] = n[3:0];
                  hit = 1'b1;
               end
            end
            assert (hit && seg[7]) else begin
               value_errors++;
               ok = 1'b0;
               $display("[ERROR] %0t bad segments %b on digit %0d", $time, seg, digit);
            end
         end
      end
      assert (seen == 8'hFF) else begin
         other_errors++;
         ok = 1'b0;
         $display("The display scan never lit every digit (seen %b)", seen);
      end
   endtask

   // Let the counts settle, then compare the scanned display
   task automatic check_display(input logic [31:0] exp, input string what);
      logic [31:0] got;
      bit          ok;
      repeat (SETTLE_CYCLES) @(negedge clk);
      read_display(got, ok);
      assert (!ok || got == exp) else begin
         value_errors++;
         $display("[ERROR] %0t %s: display %h, expected %h", $time, what, got, exp);
      end
   endtask

   // RGB bits as {17 r g b, 16 r g b}
   task automatic wait_rgb(input logic [5:0] exp, input string what);
      logic [5:0] rgb;
      rgb = ~exp;
      for (int c = 0; c < LED_CYCLES && rgb != exp; c++) begin
         @(negedge clk);
         rgb = {led17_r, led17_g, led17_b, led16_r, led16_g, led16_b};
      end
      assert (rgb == exp) else begin
         value_errors++;
         $display("[ERROR] %0t %s: rgb %b, expected %b", $time, what, rgb, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic reset_state();
      assert (led == 16'h0000) else begin
         value_errors++;
         $display("[ERROR] %0t reset_state: led %h after reset", $time, led);
      end
      check_display(32'h0000_0000, "reset_state");
   endtask

   task automatic switch_mirror();
      logic [15:0] word;
      int          bit_idx;
      bit          bad;
      word = 16'($urandom());
      sw   = word;
      for (int c = 0; c < LED_CYCLES && led != word; c++) @(negedge clk);
      assert (led == word) else begin
         value_errors++;
         $display("[ERROR] %0t switch_mirror: led %h, expected %h", $time, led, word);
      end
      // Short glitch on one switch must be filtered
      bit_idx = $urandom() % 16;
      bad = 1'b0;
      sw[bit_idx] = ~sw[bit_idx];
      repeat (3) begin
         @(negedge clk);
         if (led != word) bad = 1'b1;
      end
      sw = word;
      repeat (LED_CYCLES + 3) begin
         @(negedge clk);
         if (led != word) bad = 1'b1;
      end
      assert (!bad) else begin
         value_errors++;
         $display("[ERROR] %0t switch_mirror: 3-cycle pulse on sw[%0d] reached led",
                  $time, bit_idx);
      end
   endtask

   task automatic press_counts();
      int plan_presses [4];
      plan_presses = '{3, 1, 2, 5};
      for (int b = 0; b < 4; b++) begin
         repeat (plan_presses[b]) begin
            press(b, 0);
            count_press(b);
         end
      end
      check_display(expected_word(), "press_counts");
   endtask

   task automatic bounce_reject();
      press(2, BOUNCE_TOGGLES);
      count_press(2);
      check_display(expected_word(), "bounce_reject");
   endtask

   task automatic center_clear();
      press(4, 0);
      count_press(4);
      check_display(32'h0000_0000, "center_clear");
   endtask

   task automatic rgb_map();
      btnl = 1'b1;
      btnu = 1'b1;
      wait_rgb(6'b111_000, "rgb_map left+up");
      count_press(0);
      count_press(2);
      btnl = 1'b0;
      btnu = 1'b0;
      wait_rgb(6'b000_000, "rgb_map release");
      btnr = 1'b1;
      wait_rgb(6'b000_100, "rgb_map right");
      count_press(1);
      btnr = 1'b0;
      wait_rgb(6'b000_000, "rgb_map release");
      // Held buttons count as presses too
      check_display(expected_word(), "rgb_map");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rst_n = 1'b0;
      sw    = '0;
      btnc  = 1'b0;
      btnu  = 1'b0;
      btnl  = 1'b0;
      btnr  = 1'b0;
      btnd  = 1'b0;
      value_errors = 0;
      other_errors = 0;
      for (int i = 0; i < 4; i++) exp_cnt[i] = 8'h00;
      lit_table = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                    7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
      seed_ret = $urandom(80);
      // Two rising edges in reset, release on the next falling edge
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      reset_state();
      switch_mirror();
      press_counts();
      bounce_reject();
      center_clear();
      rgb_map();

      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- src.f
+incdir+common
common/panel_pkg.sv
debounce/debounce.sv
display/display_8hex.sv
design/panel_ctrl.sv
design/nexys4_panel.sv
testbench/tb_nexys4_panel.sv
